// File: wb_err_gen.f
verilog/wb_err_gen_pkg.sv
verilog/wb_req_decode.sv
verilog/wb_err_responder.sv
verilog/wb_rsp_mux.sv
verilog/wb_err_gen_top.sv
sim/wb_clk_gen.sv
sim/wb_err_gen_tb.sv

// File: Makefile
# Verilator build and run for the Wishbone error generator

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = wb_err_gen_tb
FILELIST  = wb_err_gen.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run, look for the pass message"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/wb_err_gen_tb.sv
/*
 * Testbench for the Wishbone error generator
 * Target model with random stalls, stimulus table, in-order response checks
 */
`default_nettype none

module wb_err_gen_tb
   import wb_err_gen_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int                   RST_CYCLES = 16;    // reset length
   localparam int                   CYC_PER_TX = 40;    // timeout budget per entry
   localparam logic [DAT_WIDTH-1:0] RD_XOR     = 16'hA5C3; // target read data pattern

   typedef enum logic { EXP_ACK, EXP_ERR } exp_rsp_t;   // expected termination

   typedef struct packed {
      req_kind_t            kind;                       // pass or bad
      logic                 we;                         // write
      logic [ADR_WIDTH-1:0] adr;                        // address
      logic [TGT_CNT-1:0]   tgtsel;                     // target select
      exp_rsp_t             rsp;                        // ack or err
   } tbl_entry_t;

   typedef struct packed {
      exp_rsp_t             rsp;                        // ack or err
      logic [DAT_WIDTH-1:0] dat;                        // expected read data
      int                   acc_cycle;                  // cycle of acceptance
   } exp_item_t;

   logic       clk;                                     // to async_rst_i, the clock port
   logic       rst;                                     // to clk_i, the reset port
   wb_req_t    itr_req;                                 // initiator request
   wb_rsp_t    itr_rsp;                                 // response to initiator
   wb_req_t    tgt_req;                                 // request at target
   wb_rsp_t    tgt_rsp;                                 // target model response
   tbl_entry_t tbl[$];                                  // stimulus table
   exp_item_t  exp_q[$];                                // responses still owed
   int         cycle_cnt = 0;                           // clocks since start
   integer     seed      = 90809;                       // target stall seed

   wb_clk_gen #(.HALF_PERIOD(5), .RST_CYCLES(RST_CYCLES)) u_clk (
      .clk_o (clk),
      .rst_o (rst)
   );

   wb_err_gen_top dut (
      .async_rst_i (clk),
      .clk_i       (rst),
      .itr_req_i   (itr_req),
      .itr_rsp_o   (itr_rsp),
      .tgt_req_o   (tgt_req),
      .tgt_rsp_i   (tgt_rsp)
   );

   //--------------------
   // error reporting
   //--------------------
   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic value_error(input string sig, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, act_v);
      abort_run();
   endtask

   task automatic run_error(input string what);
      $display("Error at %0t: %s", $time, what);
      abort_run();
   endtask

   //--------------------
   // stimulus table
   //--------------------
   task automatic add_entry(input req_kind_t kind, input logic we,
                            input logic [ADR_WIDTH-1:0] adr,
                            input logic [TGT_CNT-1:0] tgtsel, input exp_rsp_t rsp);
      tbl_entry_t ent;
      ent = '{kind: kind, we: we, adr: adr, tgtsel: tgtsel, rsp: rsp};
      tbl.push_back(ent);
   endtask

   task automatic build_table();
      add_entry(REQ_PASS, 1'b0, 16'h0010, 4'b0001, EXP_ACK);  // single read
      add_entry(REQ_PASS, 1'b1, 16'h0022, 4'b0100, EXP_ACK);  // single write
      add_entry(REQ_BAD,  1'b0, 16'h0100, 4'b0000, EXP_ERR);  // waits for the write ack
      add_entry(REQ_BAD,  1'b1, 16'h0104, 4'b0000, EXP_ERR);  // back to back bad
      add_entry(REQ_BAD,  1'b0, 16'h0108, 4'b0000, EXP_ERR);
      add_entry(REQ_PASS, 1'b0, 16'h0200, 4'b1000, EXP_ACK);  // held behind err
      add_entry(REQ_PASS, 1'b0, 16'h0204, 4'b0010, EXP_ACK);
      add_entry(REQ_PASS, 1'b1, 16'h0208, 4'b0001, EXP_ACK);
      add_entry(REQ_BAD,  1'b0, 16'h0300, 4'b0000, EXP_ERR);  // after pending passes
      add_entry(REQ_PASS, 1'b0, 16'h0400, 4'b1100, EXP_ACK);
      add_entry(REQ_BAD,  1'b0, 16'h0404, 4'b0000, EXP_ERR);
      add_entry(REQ_PASS, 1'b0, 16'h0408, 4'b0110, EXP_ACK);
      add_entry(REQ_PASS, 1'b0, 16'h040C, 4'b1111, EXP_ACK);
      add_entry(REQ_PASS, 1'b0, 16'h0410, 4'b0001, EXP_ACK);
      add_entry(REQ_BAD,  1'b1, 16'h0500, 4'b0000, EXP_ERR);
      add_entry(REQ_BAD,  1'b0, 16'h0504, 4'b0000, EXP_ERR);
      add_entry(REQ_PASS, 1'b1, 16'h0600, 4'b0010, EXP_ACK);
      add_entry(REQ_BAD,  1'b0, 16'h0604, 4'b0000, EXP_ERR);
      add_entry(REQ_PASS, 1'b0, 16'h0608, 4'b0100, EXP_ACK);
      add_entry(REQ_PASS, 1'b0, 16'hFFFE, 4'b1000, EXP_ACK);  // top of address space
   endtask

   //--------------------
   // target model
   //--------------------
   initial
   begin : target_model
      wb_rsp_t rsp;
      logic    taken;
      tgt_rsp <= '0;
      forever
      begin
         @(posedge clk);
         taken     = tgt_req.cyc & tgt_req.stb & ~tgt_rsp.stall;  // request taken last cycle
         rsp       = '0;
         rsp.ack   = ~rst & taken;                    // ack one cycle later
         rsp.dat   = (taken && !tgt_req.we) ? (tgt_req.adr ^ RD_XOR) : '0;
         rsp.stall = ~rst & (($random(seed) & 3) == 0); // about one cycle in four
         tgt_rsp  <= rsp;
      end
   end

   //--------------------
   // initiator driver
   //--------------------
   initial
   begin : drive_initiator
      tbl_entry_t ent;
      wb_req_t    req;
      exp_item_t  item;
      req_kind_t  prev_kind;
      itr_req <= '0;
      prev_kind = REQ_NONE;
      build_table();
      @(posedge clk);
      while (rst)
         @(posedge clk);
      repeat (2) @(posedge clk);                      // idle bus just after reset
      foreach (tbl[i])
      begin
         ent        = tbl[i];
         req        = '0;
         req.cyc    = 1'b1;
         req.stb    = 1'b1;
         req.we     = ent.we;
         req.sel    = '1;
         req.adr    = ent.adr;
         req.dat    = ~ent.adr;                       // write data
         req.tgtsel = ent.tgtsel;
         itr_req   <= req;
         @(posedge clk);
         if (ent.kind == REQ_BAD && prev_kind == REQ_BAD)  // err in the very next cycle
            assert (!itr_rsp.stall)
            else value_error("itr_rsp_o.stall", 64'd0, 64'(itr_rsp.stall));
         while (itr_rsp.stall)
            @(posedge clk);
         // accepted at this edge
         if (ent.kind == REQ_PASS)
            assert (tgt_req == itr_req)
            else value_error("tgt_req_o", 64'(itr_req), 64'(tgt_req));
         else
            assert (!tgt_req.stb) else value_error("tgt_req_o.stb", 64'd0, 64'(tgt_req.stb));
         item.rsp       = ent.rsp;
         item.dat       = (ent.rsp == EXP_ACK && !ent.we) ? (ent.adr ^ RD_XOR) : '0;
         item.acc_cycle = cycle_cnt;
         exp_q.push_back(item);
         prev_kind = ent.kind;
      end
      itr_req.stb <= 1'b0;                            // cyc stays up until drained
      while (exp_q.size() != 0)
         @(posedge clk);
      itr_req <= '0;
      repeat (4) @(posedge clk);                      // catch late duplicates
      $display("Simulation finished: PASS");
      $finish;
   end

   //--------------------
   // monitors
   //--------------------
   always @(posedge clk)
   begin : check_bus
      if (rst)
         assert (!itr_rsp.err) else value_error("itr_rsp_o.err", 64'd0, 64'(itr_rsp.err));
      if (tgt_req.stb)                                // only pass requests reach the target
         assert (itr_req.cyc && itr_req.stb && itr_req.tgtsel != '0)
         else run_error("tgt_req_o stb high without a pass request presented");
   end

   always @(posedge clk)
   begin : check_responses
      exp_item_t  e;
      logic [1:0] exp_flags;
      if (!rst && (itr_rsp.ack || itr_rsp.err || itr_rsp.rty))
      begin
         assert (exp_q.size() != 0) else run_error("response arrived with nothing owed");
         if (exp_q.size() != 0)
         begin
            e         = exp_q.pop_front();
            exp_flags = (e.rsp == EXP_ERR) ? 2'b01 : 2'b10;  // {ack, err}
            assert (!itr_rsp.rty) else value_error("itr_rsp_o.rty", 64'd0, 64'(itr_rsp.rty));
            assert ({itr_rsp.ack, itr_rsp.err} == exp_flags)
            else value_error("itr_rsp_o.{ack,err}", 64'(exp_flags),
                             64'({itr_rsp.ack, itr_rsp.err}));
            assert (itr_rsp.dat == e.dat)
            else value_error("itr_rsp_o.dat", 64'(e.dat), 64'(itr_rsp.dat));
            if (e.rsp == EXP_ERR)                     // err exactly one clock late
               assert (cycle_cnt == e.acc_cycle + 1)
               else value_error("err latency", 64'(1), 64'(cycle_cnt - e.acc_cycle));
         end
      end
   end

   //--------------------
   // timeout
   //--------------------
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_cnt < RST_CYCLES + CYC_PER_TX * tbl.size())
      else run_error("timeout, responses did not all arrive in time");
   end

endmodule

`default_nettype wire

// File: sim/wb_clk_gen.sv
/*
 * Testbench clock and reset generator
 */
`default_nettype none

module wb_clk_gen #(
   parameter int HALF_PERIOD = 5,                       // ns, 10 ns period
   parameter int RST_CYCLES  = 16                       // reset length in clocks
)(
   output logic clk_o,                                  // free running clock
   output logic rst_o                                   // active high reset
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;              // toggle every half period
   end

   initial
   begin
      rst_o <= 1'b1;                                    // asserted from time zero
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;                                    // release on a rising edge
   end

endmodule

`default_nettype wire

// File: verilog/wb_err_gen_top.sv
/*
 * Wishbone error generator top level
 * Decoder, error responder and response mux
 */
`default_nettype none

module wb_err_gen_top
   import wb_err_gen_pkg::*;
(
   //--------------------
   // clock and reset
   //--------------------
   input  wire      async_rst_i,                        // clock
   input  wire      clk_i,                              // async reset, active high

   //--------------------
   // initiator side
   //--------------------
   input  wb_req_t  itr_req_i,                          // request in
   output wb_rsp_t  itr_rsp_o,                          // response out

   //--------------------
   // target side
   //--------------------
   output wb_req_t  tgt_req_o,                          // request out
   input  wb_rsp_t  tgt_rsp_i                           // response in
);

   req_kind_t kind;                                     // request classification
   logic      accept;                                   // request taken
   logic      hold;                                     // ordering stall
   logic      err_due;                                  // local err this cycle

   // classify and stall
   wb_req_decode u_decode (
      .async_rst_i (async_rst_i),
      .clk_i       (clk_i),
      .itr_req_i   (itr_req_i),
      .tgt_rsp_i   (tgt_rsp_i),
      .err_due_i   (err_due),
      .kind_o      (kind),
      .accept_o    (accept),
      .hold_o      (hold)
   );

   // error for bad requests
   wb_err_responder u_responder (
      .async_rst_i (async_rst_i),
      .clk_i       (clk_i),
      .kind_i      (kind),
      .accept_i    (accept),
      .err_due_o   (err_due)
   );

   // gate and merge
   wb_rsp_mux u_mux (
      .itr_req_i   (itr_req_i),
      .tgt_rsp_i   (tgt_rsp_i),
      .kind_i      (kind),
      .hold_i      (hold),
      .err_due_i   (err_due),
      .tgt_req_o   (tgt_req_o),
      .itr_rsp_o   (itr_rsp_o)
   );

endmodule

`default_nettype wire

// File: verilog/wb_rsp_mux.sv
/*
 * Target request gating and initiator response merge
 * Purely combinational
 */
`default_nettype none

module wb_rsp_mux
   import wb_err_gen_pkg::*;
(
   input  wb_req_t    itr_req_i,                        // request from initiator
   input  wb_rsp_t    tgt_rsp_i,                        // response from target
   input  req_kind_t  kind_i,                           // request kind this cycle
   input  wire        hold_i,                           // ordering stall
   input  wire        err_due_i,                        // local error response
   output wb_req_t    tgt_req_o,                        // request to target
   output wb_rsp_t    itr_rsp_o                         // response to initiator
);

   logic to_tgt;                                        // request may reach the target

   assign to_tgt = (kind_i == REQ_PASS) & ~hold_i;

   //--------------------
   // target side
   //--------------------
   // everything forwarded as is, only stb is masked
   always_comb
   begin
      tgt_req_o     = itr_req_i;
      tgt_req_o.stb = itr_req_i.stb & to_tgt;           // bad or held requests stay local
   end

   //--------------------
   // initiator side
   //--------------------
   // The ordering stalls keep target responses and local errors out of the
   // same cycle, so a plain OR is enough for err.
   always_comb
   begin
      itr_rsp_o.ack = tgt_rsp_i.ack;
      itr_rsp_o.rty = tgt_rsp_i.rty;
      itr_rsp_o.err = tgt_rsp_i.err | err_due_i;        // target error or ours
      if (err_due_i)
         itr_rsp_o.dat = '0;                            // error data is zero
      else
         itr_rsp_o.dat = tgt_rsp_i.dat;
      // target stall only matters for a request going there
      itr_rsp_o.stall = ((kind_i == REQ_PASS) & tgt_rsp_i.stall) | hold_i;
   end

endmodule

`default_nettype wire

// File: verilog/wb_err_responder.sv
/*
 * Error responder FSM
 * One err cycle for each accepted bad request, one clock after acceptance
 */
`default_nettype none

module wb_err_responder
   import wb_err_gen_pkg::*;
(
   input  wire        async_rst_i,                      // clock
   input  wire        clk_i,                            // async reset, active high
   input  req_kind_t  kind_i,                           // request kind this cycle
   input  wire        accept_i,                         // request taken this cycle
   output logic       err_due_o                         // err goes out this cycle
);

   err_state_t state_q;                                 // current state
   err_state_t state_d;                                 // next state
   logic       bad_acc;                                 // bad request taken

   assign bad_acc = accept_i & (kind_i == REQ_BAD);

   //--------------------
   // state register
   //--------------------
   always_ff @(posedge async_rst_i or posedge clk_i)
   begin
      if (clk_i)
         state_q <= ERR_IDLE;
      else
         state_q <= state_d;
   end

   //--------------------
   // transitions
   //--------------------
   //  IDLE  --bad_acc-->  RESPOND
   //  RESPOND stays while bad requests keep coming, one err per cycle
   always_comb
   begin
      state_d = state_q;                                // default hold
      case (state_q)
         ERR_IDLE:
         begin
            if (bad_acc)
               state_d = ERR_RESPOND;                   // answer next cycle
         end
         ERR_RESPOND:
         begin
            if (!bad_acc)
               state_d = ERR_IDLE;                      // last err this cycle
         end
         default:
         begin
            state_d = ERR_IDLE;
         end
      endcase
   end

   // Moore output, err only in RESPOND
   assign err_due_o = (state_q == ERR_RESPOND);

endmodule

`default_nettype wire

// File: verilog/wb_req_decode.sv
/*
 * Request classifier and ordering stall logic
 * Counts pass-through responses still owed by the target
 */
`default_nettype none

module wb_req_decode
   import wb_err_gen_pkg::*;
(
   input  wire        async_rst_i,                      // clock
   input  wire        clk_i,                            // async reset, active high
   input  wb_req_t    itr_req_i,                        // request from initiator
   input  wb_rsp_t    tgt_rsp_i,                        // response from target
   input  wire        err_due_i,                        // error response on the bus
   output req_kind_t  kind_o,                           // classification this cycle
   output logic       accept_o,                         // request taken this cycle
   output logic       hold_o                            // ordering stall
);

   logic                  present;                      // cyc and stb both high
   logic                  pass_acc;                     // pass request taken
   logic                  tgt_done;                     // target answered one request
   logic                  pend_full;                    // counter cannot grow
   logic [PEND_WIDTH-1:0] pend_cnt;                     // pass responses still owed

   //--------------------
   // classification
   //--------------------
   assign present = itr_req_i.cyc & itr_req_i.stb;

   always_comb
   begin
      if (!present)
         kind_o = REQ_NONE;
      else if (|itr_req_i.tgtsel)
         kind_o = REQ_PASS;                             // at least one target
      else
         kind_o = REQ_BAD;                              // nobody would answer
   end

   //--------------------
   // ordering stalls
   //--------------------
   // A bad request waits until the target has answered everything, and a pass
   // request waits while an error is still going out. The one-cycle error
   // latency means the owed error is exactly the cycle where err_due is high.
   assign pend_full = &pend_cnt;

   always_comb
   begin
      case (kind_o)
         REQ_PASS: hold_o = err_due_i | pend_full;      // error first, or no room to count
         REQ_BAD:  hold_o = |pend_cnt;                  // target responses first
         default:  hold_o = 1'b0;
      endcase
   end

   // target stall only counts for requests that go to the target
   assign accept_o = present & ~hold_o & ~((kind_o == REQ_PASS) & tgt_rsp_i.stall);

   //--------------------
   // outstanding counter
   //--------------------
   assign pass_acc = accept_o & (kind_o == REQ_PASS);
   assign tgt_done = tgt_rsp_i.ack | tgt_rsp_i.err | tgt_rsp_i.rty;

   always_ff @(posedge async_rst_i or posedge clk_i)
   begin
      if (clk_i)
         pend_cnt <= '0;
      else if (pass_acc && !tgt_done)
         pend_cnt <= pend_cnt + 1'b1;                   // one more owed
      else if (!pass_acc && tgt_done)
         pend_cnt <= pend_cnt - 1'b1;                   // one answered
   end

endmodule

`default_nettype wire

// File: verilog/wb_err_gen_pkg.sv
/*
 * Shared widths for the Wishbone error generator
 * Request and response structs, request kind and responder state enums
 */
`default_nettype none

package wb_err_gen_pkg;

   //--------------------
   // bus widths
   //--------------------
   localparam int unsigned ADR_WIDTH  = 16;             // address bus
   localparam int unsigned DAT_WIDTH  = 16;             // read and write data
   localparam int unsigned SEL_WIDTH  = 2;              // byte selects
   localparam int unsigned TGT_CNT    = 4;              // target select bits
   localparam int unsigned PEND_WIDTH = 4;              // outstanding response count

   //--------------------
   // bus structs
   //--------------------
   // initiator to target
   typedef struct packed {
      logic                 cyc;                        // bus cycle indicator
      logic                 stb;                        // access request
      logic                 we;                         // write enable
      logic                 lock;                       // uninterruptable cycle
      logic [SEL_WIDTH-1:0] sel;                        // write data selects
      logic [ADR_WIDTH-1:0] adr;                        // address
      logic [DAT_WIDTH-1:0] dat;                        // write data
      logic [TGT_CNT-1:0]   tgtsel;                     // one bit per target, all zero is bad
   } wb_req_t;

   // target to initiator
   typedef struct packed {
      logic                 ack;                        // cycle acknowledge
      logic                 err;                        // error response
      logic                 rty;                        // retry response
      logic                 stall;                      // access delay
      logic [DAT_WIDTH-1:0] dat;                        // read data
   } wb_rsp_t;

   //--------------------
   // enums
   //--------------------
   // kind of the request presented this cycle
   typedef enum logic [1:0] {
      REQ_NONE = 2'd0,                                  // no cyc and stb
      REQ_PASS = 2'd1,                                  // some target selected
      REQ_BAD  = 2'd2                                   // no target selected
   } req_kind_t;

   // error responder FSM
   typedef enum logic {
      ERR_IDLE    = 1'b0,                               // nothing owed
      ERR_RESPOND = 1'b1                                // err on the bus this cycle
   } err_state_t;

endpackage

`default_nettype wire
